// ==== flit_buffer.f ====
flit_buffer_pkg.sv
vc_pointers.sv
shared_queue_ram.sv
flit_buffer.sv
flit_buffer_checker.sv
flit_buffer_tb.sv

// ==== flit_buffer.sv ====
`timescale 1ns/10ps

module flit_buffer
    import flit_buffer_pkg::*;
#(
    parameter int num_vc = NUM_VC,
    parameter int vc_depth = VC_DEPTH,
    // 1 enables speculative switch allocation bypass
    parameter int ssa_en = 1,
    localparam int vc_w = (num_vc > 1) ? $clog2(num_vc) : 1,
    localparam int ptr_w = (vc_depth > 1) ? $clog2(vc_depth) : 1,
    localparam int addr_w = vc_w + ptr_w
) (
    input  logic         clk,
    input  logic         reset,
    input  flit_t        din,
    input  vc_mask_t     vc_num_wr,
    input  vc_mask_t     vc_num_rd,
    input  logic         wr_en,
    input  logic         rd_en,
    // speculative read request, only looked at when rd_en is low
    input  vc_mask_t     ssa_rd,
    output stored_flit_t dout,
    output vc_mask_t     vc_not_empty
);

    stored_flit_t      wr_flit;
    vc_mask_t          wr_mask;
    vc_mask_t          rd_mask;
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;

    // strip the vc field, the slice address already encodes it
    assign wr_flit = {din[FLIT_W-1 -: HDR_W], din[PAYLOAD_W-1:0]};

    // no write strobe, no pointer movement
    assign wr_mask = wr_en ? vc_num_wr : '0;

    // normal read wins over ssa
    assign rd_mask = rd_en ? vc_num_rd : ssa_rd;

    vc_pointers #(
        .num_vc   (num_vc),
        .vc_depth (vc_depth)
    ) u_pointers (
        .clk          (clk),
        .reset        (reset),
        .wr_mask      (wr_mask),
        .rd_mask      (rd_mask),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    // ram read port only fires on a normal read
    shared_queue_ram #(
        .ssa_en (ssa_en)
    ) u_queue (
        .clk     (clk),
        .wr_data (wr_flit),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .rd_data (dout)
    );

endmodule

// ==== flit_buffer_checker.sv ====
`timescale 1ns/10ps

module flit_buffer_checker
    import flit_buffer_pkg::*;
#(
    parameter int num_vc = NUM_VC,
    parameter int vc_depth = VC_DEPTH,
    // same offset width as the pointer block
    localparam int ptr_w = (vc_depth > 1) ? $clog2(vc_depth) : 1
) (
    input logic           clk,
    input logic           reset,
    input vc_mask_t       wr_mask,
    input vc_mask_t       rd_mask,
    input vc_mask_t       vc_num_wr,
    // occupancy counters of the bound instance
    input logic [ptr_w:0] depth [num_vc]
);

    genvar v;

    generate
        for (v = 0; v < num_vc; v++) begin : g_vc
            // full slice only takes a write when a read frees a slot
            assert property (@(posedge clk) disable iff (reset)
                (wr_mask[v] && !rd_mask[v]) |-> (int'(depth[v]) < vc_depth))
                else $error("write to full vc %0d", v);

            // empty slice read is legal only for the ssa bypass of a fresh flit
            assert property (@(posedge clk) disable iff (reset)
                (rd_mask[v] && depth[v] == '0) |-> wr_mask[v])
                else $error("read from empty vc %0d", v);
        end
    endgenerate

    // a write picks exactly one slice
    assert property (@(posedge clk) disable iff (reset)
        (wr_mask != '0) |-> $onehot(vc_num_wr))
        else $error("write select is not one-hot");

endmodule

bind vc_pointers flit_buffer_checker #(
    .num_vc   (num_vc),
    .vc_depth (vc_depth)
) u_checker (
    .clk       (clk),
    .reset     (reset),
    .wr_mask   (wr_mask),
    .rd_mask   (rd_mask),
    .vc_num_wr (vc_num_wr),
    .depth     (depth)
);

// ==== flit_buffer_pkg.sv ====
package flit_buffer_pkg;

    // default router port geometry, the top level may override
    // number of virtual channels sharing one input port
    localparam int NUM_VC = 4;

    // flits per vc slice
    // power of two only, pointers wrap by overflow
    localparam int VC_DEPTH = 4;

    // flit payload bits
    localparam int PAYLOAD_W = 32;

    // head and tail flags
    localparam int HDR_W = 2;

    // what the ram holds: header plus payload, no vc field
    localparam int STORED_W = HDR_W + PAYLOAD_W;

    // incoming flit: header on top, one-hot vc, payload at the bottom
    localparam int FLIT_W = HDR_W + NUM_VC + PAYLOAD_W;

    // one bit per vc
    // used one-hot for selects, multi-hot for ssa requests
    typedef logic [NUM_VC-1:0] vc_mask_t;

    // flit as stored in ram and driven on dout
    typedef logic [STORED_W-1:0] stored_flit_t;

    // full flit as received from the link
    typedef logic [FLIT_W-1:0] flit_t;

endpackage

// ==== flit_buffer_tb.sv ====
`timescale 1ns/10ps

module flit_buffer_tb
    import flit_buffer_pkg::*;
();

    logic         clk;
    logic         reset;
    flit_t        din;
    vc_mask_t     vc_num_wr;
    vc_mask_t     vc_num_rd;
    logic         wr_en;
    logic         rd_en;
    vc_mask_t     ssa_rd;
    stored_flit_t dout;
    vc_mask_t     vc_not_empty;

    // one entry per trace line
    int           tr_test   [$];
    logic         tr_wr_en  [$];
    vc_mask_t     tr_wr_vc  [$];
    flit_t        tr_din    [$];
    logic         tr_rd_en  [$];
    vc_mask_t     tr_rd_vc  [$];
    vc_mask_t     tr_ssa    [$];
    // bit0 vc_not_empty, bit1 dout
    logic [1:0]   tr_chk    [$];
    stored_flit_t tr_dout   [$];
    vc_mask_t     tr_ne     [$];

    int n_lines;
    int pass_count;
    int error_count;
    int test_checks;
    int test_errors;
    int cycle_count;
    int cycle_limit;

    flit_buffer #(
        .num_vc   (NUM_VC),
        .vc_depth (VC_DEPTH),
        .ssa_en   (1)
    ) UUT (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .ssa_rd       (ssa_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // comment lines start with #, data lines hold ten hex columns
    task automatic load_trace(output int lines);
        int           fd;
        int           code;
        int           n;
        string        line;
        int           tnum;
        logic         w;
        vc_mask_t     wv;
        flit_t        d;
        logic         r;
        vc_mask_t     rv;
        vc_mask_t     s;
        logic [1:0]   c;
        stored_flit_t ed;
        vc_mask_t     en;
        lines = 0;
        fd = $fopen("flit_buffer_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open trace file flit_buffer_trace.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                tnum, w, wv, d, r, rv, s, c, ed, en);
                    if (n == 10) begin
                        tr_test.push_back(tnum);
                        tr_wr_en.push_back(w);
                        tr_wr_vc.push_back(wv);
                        tr_din.push_back(d);
                        tr_rd_en.push_back(r);
                        tr_rd_vc.push_back(rv);
                        tr_ssa.push_back(s);
                        tr_chk.push_back(c);
                        tr_dout.push_back(ed);
                        tr_ne.push_back(en);
                        lines++;
                    end else if (n > 0) begin
                        $display("malformed trace line: %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input int i);
        wr_en     = tr_wr_en[i];
        vc_num_wr = tr_wr_vc[i];
        din       = tr_din[i];
        rd_en     = tr_rd_en[i];
        vc_num_rd = tr_rd_vc[i];
        ssa_rd    = tr_ssa[i];
    endtask

    // quiet bus, no pointer moves
    task automatic apply_idle();
        wr_en     = 1'b0;
        vc_num_wr = '0;
        din       = '0;
        rd_en     = 1'b0;
        vc_num_rd = '0;
        ssa_rd    = '0;
    endtask

    task automatic compare_flit(input string name, input stored_flit_t exp,
                                input stored_flit_t act, input int i);
        test_checks++;
        if (act !== exp) begin
            $display("Error %s: expected %h, got %h (test %0d, line %0d)",
                     name, exp, act, tr_test[i], i);
            error_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_mask(input string name, input vc_mask_t exp,
                                input vc_mask_t act, input int i);
        test_checks++;
        if (act !== exp) begin
            $display("Error %s: expected %h, got %h (test %0d, line %0d)",
                     name, exp, act, tr_test[i], i);
            error_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_line(input int i);
        if (tr_chk[i][0]) begin
            compare_mask("vc_not_empty", tr_ne[i], vc_not_empty, i);
        end
        if (tr_chk[i][1]) begin
            compare_flit("dout", tr_dout[i], dout, i);
        end
    endtask

    task automatic report_test(input int tnum);
        $display("test %0d %s: %0d checks, %0d errors", tnum,
                 (test_errors == 0) ? "ok" : "wrong", test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // watchdog, limit known once the trace is loaded
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: trace did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        pass_count  = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        cycle_limit = 0;
        apply_idle();
        load_trace(n_lines);
        if (n_lines == 0) begin
            $display("no stimulus lines were read from the trace");
            error_count++;
        end
        cycle_limit = n_lines + 20;

        // two cycles of reset, released off the edge
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        if (n_lines > 0) begin
            apply_line(0);
        end

        // line i sampled at this edge, checked just before the next one
        for (int i = 0; i < n_lines; i++) begin
            @(posedge clk);
            #10;
            if (i + 1 < n_lines) begin
                apply_line(i + 1);
            end else begin
                apply_idle();
            end
            #80;
            check_line(i);
            if (i + 1 == n_lines || tr_test[i + 1] != tr_test[i]) begin
                report_test(tr_test[i]);
            end
        end

        $display("checks passed: %0d, errors: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== flit_buffer_trace.txt ====
# test wr_en vc_num_wr din rd_en vc_num_rd ssa_rd chk exp_dout exp_vc_not_empty
# all hex; din = {hdr, vc, payload}; chk bit0 vc_not_empty, bit1 dout
# reset state
1 0 0 0000000000 0 0 0 1 000000000 0
# vc 0 write three, read three
2 1 1 2111110000 0 0 0 1 000000000 1
2 1 1 0122220000 0 0 0 1 000000000 1
2 1 1 1133330000 0 0 0 1 000000000 1
2 0 0 0000000000 1 1 0 3 211110000 1
2 0 0 0000000000 1 1 0 3 022220000 1
2 0 0 0000000000 1 1 0 3 133330000 0
# interleaved writes on all vcs, reads in another vc order
3 1 1 210a000001 0 0 0 1 000000000 1
3 1 2 220b000001 0 0 0 1 000000000 3
3 1 4 240c000001 0 0 0 1 000000000 7
3 1 8 280d000001 0 0 0 1 000000000 f
3 1 1 110a000002 0 0 0 1 000000000 f
3 1 4 140c000002 0 0 0 1 000000000 f
3 1 8 180d000002 0 0 0 1 000000000 f
3 1 2 120b000002 0 0 0 1 000000000 f
3 0 0 0000000000 1 8 0 3 20d000001 f
3 0 0 0000000000 1 2 0 3 20b000001 f
3 0 0 0000000000 1 1 0 3 20a000001 f
3 0 0 0000000000 1 4 0 3 20c000001 f
3 0 0 0000000000 1 4 0 3 10c000002 b
3 0 0 0000000000 1 1 0 3 10a000002 a
3 0 0 0000000000 1 8 0 3 10d000002 2
3 0 0 0000000000 1 2 0 3 10b000002 0
# vc 2 fill, drain, refill across the pointer wrap
4 1 4 240e000001 0 0 0 1 000000000 4
4 1 4 040e000002 0 0 0 1 000000000 4
4 1 4 040e000003 0 0 0 1 000000000 4
4 1 4 140e000004 0 0 0 1 000000000 4
4 0 0 0000000000 1 4 0 3 20e000001 4
4 0 0 0000000000 1 4 0 3 00e000002 4
4 0 0 0000000000 1 4 0 3 00e000003 4
4 0 0 0000000000 1 4 0 3 10e000004 0
4 1 4 240e000005 0 0 0 1 000000000 4
4 1 4 140e000006 0 0 0 1 000000000 4
4 0 0 0000000000 1 4 0 3 20e000005 4
4 0 0 0000000000 1 4 0 3 10e000006 0
# write and read on different vcs in one cycle
5 1 8 280f000001 0 0 0 1 000000000 8
5 1 2 220f000002 1 8 0 3 20f000001 2
5 1 8 180f000003 1 2 0 3 20f000002 8
5 0 0 0000000000 1 8 0 3 10f000003 0
# ssa bypass on vc 1, then a normal flit through the moved pointers
6 1 2 3205500001 0 0 2 3 305500001 0
6 0 0 0000000000 0 0 0 1 000000000 0
6 1 2 2205500002 0 0 0 1 000000000 2
6 0 0 0000000000 1 2 0 3 205500002 0

// ==== run.sh ====
#!/bin/sh
# build and run the flit buffer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module flit_buffer_tb \
    -f flit_buffer.f

out=$(./obj_dir/Vflit_buffer_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// ==== shared_queue_ram.sv ====
`timescale 1ns/10ps

module shared_queue_ram
    import flit_buffer_pkg::*;
#(
    // 1 adds the bypass register for ssa reads
    parameter int ssa_en = 1,
    localparam int vc_w = (NUM_VC > 1) ? $clog2(NUM_VC) : 1,
    localparam int ptr_w = (VC_DEPTH > 1) ? $clog2(VC_DEPTH) : 1,
    // {vc, offset}, same split as the pointer block
    localparam int addr_w = vc_w + ptr_w
) (
    input  logic              clk,
    input  stored_flit_t      wr_data,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [addr_w-1:0] rd_addr,
    input  logic              wr_en,
    input  logic              rd_en,
    output stored_flit_t      rd_data
);

    // all vc slices back to back, maps onto one block ram
    stored_flit_t mem [NUM_VC * VC_DEPTH];

    // registered ram output, holds between reads
    stored_flit_t ram_q;

    // simple dual port: write and read in the same cycle
    // a same-address read returns the old word
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            ram_q <= mem[rd_addr];
        end
    end

    generate
        if (ssa_en != 0) begin : g_bypass
            // incoming flit captured every cycle
            stored_flit_t bypass_q;
            // was the last cycle a normal read
            logic         rd_en_q;

            always_ff @(posedge clk) begin
                bypass_q <= wr_data;
                rd_en_q  <= rd_en;
            end

            // non-read cycles show the flit written one cycle back
            assign rd_data = rd_en_q ? ram_q : bypass_q;
        end else begin : g_direct
            assign rd_data = ram_q;
        end
    endgenerate

endmodule

// ==== vc_pointers.sv ====
`timescale 1ns/10ps

module vc_pointers
    import flit_buffer_pkg::*;
#(
    parameter int num_vc = NUM_VC,
    parameter int vc_depth = VC_DEPTH,
    // vc number bits, upper part of the ram address
    localparam int vc_w = (num_vc > 1) ? $clog2(num_vc) : 1,
    // offset inside one vc slice
    localparam int ptr_w = (vc_depth > 1) ? $clog2(vc_depth) : 1,
    localparam int addr_w = vc_w + ptr_w
) (
    input  logic              clk,
    input  logic              reset,
    // gated write strobe per vc
    input  vc_mask_t          wr_mask,
    // normal read or ssa read per vc
    input  vc_mask_t          rd_mask,
    // raw one-hot selects, used for address formation only
    input  vc_mask_t          vc_num_wr,
    input  vc_mask_t          vc_num_rd,
    output logic [addr_w-1:0] wr_addr,
    output logic [addr_w-1:0] rd_addr,
    output vc_mask_t          vc_not_empty
);

    // slot offset within a slice
    typedef logic [ptr_w-1:0] ptr_t;
    // occupancy, one extra bit so a full slice fits
    typedef logic [ptr_w:0] depth_t;

    ptr_t   wr_ptr [num_vc];
    ptr_t   rd_ptr [num_vc];
    depth_t depth  [num_vc];

    // binary vc numbers from the one-hot selects
    logic [vc_w-1:0] wr_vc;
    logic [vc_w-1:0] rd_vc;

    // pointer of the selected vc
    ptr_t wr_sel_ptr;
    ptr_t rd_sel_ptr;

    // per-vc counters
    // no wrap logic needed, vc_depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < num_vc; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                depth[v]  <= '0;
            end
        end else begin
            for (int v = 0; v < num_vc; v++) begin
                if (wr_mask[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + 1'b1;
                end
                if (rd_mask[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + 1'b1;
                end
                // write and read together leave occupancy alone
                // this also covers the ssa bypass of a fresh flit
                if (wr_mask[v] && !rd_mask[v]) begin
                    depth[v] <= depth[v] + 1'b1;
                end else if (!wr_mask[v] && rd_mask[v]) begin
                    depth[v] <= depth[v] - 1'b1;
                end
            end
        end
    end

    // one-hot to binary and one-hot pointer mux in one pass
    // selects are one-hot, so or-ing is enough
    always_comb begin
        wr_vc      = '0;
        rd_vc      = '0;
        wr_sel_ptr = '0;
        rd_sel_ptr = '0;
        for (int v = 0; v < num_vc; v++) begin
            if (vc_num_wr[v]) begin
                wr_vc      |= vc_w'(v);
                wr_sel_ptr |= wr_ptr[v];
            end
            if (vc_num_rd[v]) begin
                rd_vc      |= vc_w'(v);
                rd_sel_ptr |= rd_ptr[v];
            end
        end
    end

    // vc number on top selects the slice
    assign wr_addr = {wr_vc, wr_sel_ptr};
    assign rd_addr = {rd_vc, rd_sel_ptr};

    // flags straight from the counters, no extra latency
    always_comb begin
        for (int v = 0; v < num_vc; v++) begin
            vc_not_empty[v] = (depth[v] != '0);
        end
    end

endmodule
